//--- logic/cast_pkg.sv
// Cast unit package with binary32 and int32 format constants, vector types and encodings
package cast_pkg;

  // ----------------------------------------------------------
  // Format constants
  // ----------------------------------------------------------
  localparam int unsigned FP_EXP_BITS = 8;    // binary32 exponent field
  localparam int unsigned FP_MAN_BITS = 23;   // binary32 mantissa field
  localparam int unsigned FP_BIAS     = 127;  // Exponent bias
  localparam int unsigned INT_WIDTH   = 32;   // Integer operand/result width

  // Internal mantissa holds hidden bit plus fraction, or a full integer
  localparam int unsigned MANT_WIDTH  = 32;
  // Signed exponent wide enough for the smallest subnormal after LZC
  localparam int unsigned EXP_WIDTH   = 10;
  // Shift amounts up to MANT_WIDTH+1
  localparam int unsigned SHAMT_WIDTH = 6;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  typedef logic        [INT_WIDTH-1:0]   word_t;    // Operand or result
  typedef logic        [MANT_WIDTH-1:0]  mant_t;    // Internal mantissa
  typedef logic signed [EXP_WIDTH-1:0]   exp_t;     // Unbiased/rebiased exponent
  typedef logic        [SHAMT_WIDTH-1:0] shamt_t;   // Shift or LZC amount
  typedef logic        [1:0]             rs_t;      // {round, sticky}
  typedef logic        [4:0]             status_t;  // {NV, DZ, OF, UF, NX}

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  typedef enum logic {
    I2F = 1'b0,  // Integer to float
    F2I = 1'b1   // Float to integer
  } cast_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest, ties to even
    RTZ = 3'd1,  // Towards zero
    RDN = 3'd2,  // Towards -inf
    RUP = 3'd3,  // Towards +inf
    RMM = 3'd4   // Nearest, ties away from zero
  } roundmode_e;

endpackage

//--- logic/cast_pipe_ctrl.sv
// Valid/ready control for the two cast pipeline stages and their register enables
`timescale 1ns/1ps

module cast_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  logic out_ready_i,
  output logic out_valid_o,
  output logic s1_en_o,     // Load stage-1 datapath registers
  output logic s2_en_o      // Load stage-2 datapath registers
);

  logic s1_valid_q, s2_valid_q;  // One item flag per stage
  logic s1_ready, s2_ready;

  // ----------------------------------------------------------
  // Ready chain from the output backwards
  // ----------------------------------------------------------
  // A stage advances if downstream takes its item or it holds a bubble
  assign s2_ready = out_ready_i | ~s2_valid_q;
  assign s1_ready = s2_ready    | ~s1_valid_q;

  assign in_ready_o  = s1_ready;
  assign out_valid_o = s2_valid_q;

  // Load only when an item is actually moving in
  assign s1_en_o = in_valid_i & s1_ready;
  assign s2_en_o = s1_valid_q & s2_ready;

  // ----------------------------------------------------------
  // Stage valid flags
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) s1_valid_q <= in_valid_i;  // Bubble when no input
      if (s2_ready) s2_valid_q <= s1_valid_q;  // Holds while stalled
    end
  end

endmodule

//--- logic/cast_normalize.sv
// Cast unit stage 1 with operand decode, LZC normalization and exponent unbiasing
`timescale 1ns/1ps

module cast_normalize import cast_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       s1_en_i,
  input  word_t      operand_i,
  input  cast_op_e   op_i,
  input  logic       op_mod_i,
  input  roundmode_e rnd_mode_i,
  output logic       sign_o,
  output exp_t       exp_o,       // Unbiased exponent of normalized mantissa
  output mant_t      mant_o,      // MSB set unless value is zero
  output logic       is_nan_o,    // Quiet NaN
  output logic       is_snan_o,   // Signalling NaN
  output logic       is_inf_o,
  output logic       is_zero_o,   // Float zero or integer zero for I2F
  output cast_op_e   op_o,
  output logic       op_mod_o,
  output roundmode_e rnd_mode_o
);

  logic                   src_is_int;
  logic [FP_EXP_BITS-1:0] exp_field;
  logic [FP_MAN_BITS-1:0] man_field;
  logic                   exp_zero, exp_ones, man_zero;
  logic                   is_normal, is_subnormal, any_nan;
  logic                   int_sign, in_sign;
  word_t                  int_mag;
  mant_t                  enc_mant, norm_mant;
  shamt_t                 lzc;
  exp_t                   int_exp, fp_exp;

  assign src_is_int = (op_i == I2F);

  // ----------------------------------------------------------
  // Float classification
  // ----------------------------------------------------------
  assign exp_field    = operand_i[FP_MAN_BITS +: FP_EXP_BITS];
  assign man_field    = operand_i[FP_MAN_BITS-1:0];
  assign exp_zero     = (exp_field == '0);
  assign exp_ones     = (exp_field == '1);
  assign man_zero     = (man_field == '0);
  assign is_normal    = ~exp_zero & ~exp_ones;
  assign is_subnormal = exp_zero & ~man_zero;
  assign any_nan      = exp_ones & ~man_zero;

  // Integer magnitude; only signed inputs can be negative
  assign int_sign = operand_i[INT_WIDTH-1] & ~op_mod_i;
  assign int_mag  = int_sign ? word_t'(-operand_i) : operand_i;

  // Hidden bit in front of the fraction and zero padding on top
  assign enc_mant = src_is_int ? int_mag
                  : {{(MANT_WIDTH-FP_MAN_BITS-1){1'b0}}, is_normal, man_field};
  assign in_sign  = src_is_int ? int_sign : operand_i[INT_WIDTH-1];

  // ----------------------------------------------------------
  // Normalization
  // ----------------------------------------------------------
  always_comb begin
    lzc = shamt_t'(MANT_WIDTH);  // All zero
    for (int i = 0; i < MANT_WIDTH; i++) begin
      if (enc_mant[i]) lzc = shamt_t'(MANT_WIDTH - 1 - i);  // Highest set bit wins
    end
  end

  assign norm_mant = enc_mant << lzc;
  assign int_exp   = exp_t'(MANT_WIDTH - 1) - exp_t'(lzc);
  // Subnormals use exponent 1; pad offset compensates the LZC
  assign fp_exp    = exp_t'(exp_field) + exp_t'(is_subnormal) - exp_t'(FP_BIAS)
                   - exp_t'(lzc) + exp_t'(MANT_WIDTH - 1 - FP_MAN_BITS);

  // ----------------------------------------------------------
  // Stage-1 registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sign_o     <= 1'b0;
      exp_o      <= '0;
      mant_o     <= '0;
      is_nan_o   <= 1'b0;
      is_snan_o  <= 1'b0;
      is_inf_o   <= 1'b0;
      is_zero_o  <= 1'b0;
      op_o       <= I2F;
      op_mod_o   <= 1'b0;
      rnd_mode_o <= RNE;
    end else if (s1_en_i) begin
      sign_o     <= in_sign;
      exp_o      <= src_is_int ? int_exp : fp_exp;
      mant_o     <= norm_mant;
      is_nan_o   <= ~src_is_int & any_nan & man_field[FP_MAN_BITS-1];   // Quiet bit set
      is_snan_o  <= ~src_is_int & any_nan & ~man_field[FP_MAN_BITS-1];
      is_inf_o   <= ~src_is_int & exp_ones & man_zero;
      is_zero_o  <= src_is_int ? (int_mag == '0) : (exp_zero & man_zero);
      op_o       <= op_i;
      op_mod_o   <= op_mod_i;
      rnd_mode_o <= rnd_mode_i;
    end
  end

endmodule

//--- logic/cast_align.sv
// Cast unit alignment with range checks and the final mantissa shift into round and sticky
`timescale 1ns/1ps

module cast_align import cast_pkg::*; (
  input  exp_t     exp_i,        // Unbiased exponent
  input  mant_t    mant_i,       // Normalized mantissa
  input  cast_op_e op_i,
  input  logic     op_mod_i,     // 1 = unsigned integer
  output mant_t    mant_o,       // Integer magnitude or float fraction
  output exp_t     final_exp_o,  // Biased exponent for I2F
  output rs_t      rs_o,
  output logic     of_before_o,
  output logic     uf_before_o
);

  // Mantissa sits left of the shifter with room for round and sticky bits
  localparam int unsigned SHIFT_WIDTH = 2 * MANT_WIDTH + 1;
  // Position of the float round bit with the sticky bits below it
  localparam int unsigned FP_STICKY   = 2 * MANT_WIDTH - FP_MAN_BITS - 1;

  logic [SHIFT_WIDTH-1:0] preshift, shifted;
  shamt_t                 shamt;
  exp_t                   of_limit, int_shift;
  logic                   is_f2i;

  assign is_f2i   = (op_i == F2I);
  assign preshift = {mant_i, {(MANT_WIDTH+1){1'b0}}};
  // Unsigned results reach one bit higher
  assign of_limit  = op_mod_i ? exp_t'(INT_WIDTH) : exp_t'(INT_WIDTH - 1);
  assign int_shift = exp_t'(INT_WIDTH - 1) - exp_i;

  // ----------------------------------------------------------
  // Range checks and shift amount
  // ----------------------------------------------------------
  always_comb begin
    shamt       = '0;
    final_exp_o = exp_i;
    of_before_o = 1'b0;
    uf_before_o = 1'b0;
    if (is_f2i) begin
      if (exp_i >= of_limit) begin
        of_before_o = 1'b1;                       // Saturates later without a shift
      end else if (exp_i < exp_t'(-1)) begin
        shamt       = shamt_t'(MANT_WIDTH + 1);   // Everything into sticky
        uf_before_o = 1'b1;
      end else begin
        shamt = shamt_t'(int_shift);              // Integer point after bit 0
      end
    end else begin
      // Rebias only since an int32 always lands in the normal float range
      final_exp_o = exp_i + exp_t'(FP_BIAS);
    end
  end

  assign shifted = preshift >> shamt;

  // ----------------------------------------------------------
  // Result field and round/sticky extraction
  // ----------------------------------------------------------
  always_comb begin
    if (is_f2i) begin
      mant_o = shifted[2*MANT_WIDTH -: INT_WIDTH];
      rs_o   = {shifted[MANT_WIDTH], |shifted[MANT_WIDTH-1:0]};
    end else begin
      // Drop the hidden bit and keep the fraction
      mant_o = {{(MANT_WIDTH-FP_MAN_BITS){1'b0}}, shifted[2*MANT_WIDTH-1 -: FP_MAN_BITS]};
      rs_o   = {shifted[FP_STICKY], |shifted[FP_STICKY-1:0]};
    end
  end

endmodule

//--- logic/cast_round.sv
// Cast unit stage 2 with rounding, special cases, status flags and the result register
`timescale 1ns/1ps

module cast_round import cast_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       s2_en_i,
  input  logic       sign_i,
  input  mant_t      mant_i,
  input  exp_t       final_exp_i,
  input  rs_t        rs_i,
  input  logic       of_before_i,
  input  logic       uf_before_i,
  input  logic       is_nan_i,     // Quiet NaN
  input  logic       is_snan_i,    // Signalling NaN
  input  logic       is_inf_i,
  input  logic       is_zero_i,
  input  cast_op_e   op_i,
  input  logic       op_mod_i,
  input  roundmode_e rnd_mode_i,
  output word_t      result_o,
  output status_t    status_o
);

  logic    is_f2i, any_nan, round_up;
  word_t   pre_abs, rounded_abs, int_res, int_special, fp_res, result_d;
  logic    int_is_special, int_nx, fp_nx;
  status_t status_d;

  assign is_f2i  = (op_i == F2I);
  assign any_nan = is_nan_i | is_snan_i;

  // ----------------------------------------------------------
  // Rounding
  // ----------------------------------------------------------
  // Float packs exponent and fraction so a carry bumps the exponent
  assign pre_abs = is_f2i ? mant_i
                 : {1'b0, final_exp_i[FP_EXP_BITS-1:0], mant_i[FP_MAN_BITS-1:0]};

  always_comb begin
    unique case (rnd_mode_i)
      RNE:     round_up = rs_i[1] & (rs_i[0] | pre_abs[0]);  // Tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_i) & sign_i;
      RUP:     round_up = (|rs_i) & ~sign_i;
      RMM:     round_up = rs_i[1];
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_abs + word_t'(round_up);

  // ----------------------------------------------------------
  // Integer result
  // ----------------------------------------------------------
  assign int_res = sign_i ? word_t'(-rounded_abs) : rounded_abs;

  // Positive or unsigned maximum, inverted for a negative non-NaN source
  always_comb begin
    int_special = {op_mod_i, {(INT_WIDTH-1){1'b1}}};
    if (sign_i && !any_nan) int_special = ~int_special;  // -max or 0
  end

  // Negative to unsigned only invalid if it did not round to zero
  assign int_is_special = any_nan | is_inf_i | of_before_i
                        | (sign_i & op_mod_i & (int_res != '0));
  assign int_nx = (|rs_i) | (uf_before_i & ~is_zero_i);  // Tiny nonzero is inexact

  // ----------------------------------------------------------
  // Float result and selection
  // ----------------------------------------------------------
  assign fp_res = is_zero_i ? {sign_i, {(INT_WIDTH-1){1'b0}}}
                : {sign_i, rounded_abs[INT_WIDTH-2:0]};
  assign fp_nx  = |rs_i;

  always_comb begin
    if (is_f2i) begin
      result_d = int_is_special ? int_special : int_res;
      status_d = int_is_special ? status_t'(5'b10000) : {4'b0000, int_nx};
    end else begin
      result_d = fp_res;
      status_d = {4'b0000, fp_nx};  // An int32 source can only be inexact
    end
  end

  // Stage-2 registers feed the outputs directly
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      status_o <= '0;
    end else if (s2_en_i) begin
      result_o <= result_d;
      status_o <= status_d;
    end
  end

endmodule

//--- logic/cast_unit.sv
// Two-stage pipelined converter between binary32 floats and 32-bit integers
`timescale 1ns/1ps

module cast_unit import cast_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Input side
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  word_t      operand_i,
  input  cast_op_e   op_i,
  input  logic       op_mod_i,    // 1 = unsigned integer
  input  roundmode_e rnd_mode_i,
  // Output side
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output word_t      result_o,
  output status_t    status_o
);

  logic s1_en, s2_en;  // Stage register enables

  // Stage-1 register outputs
  logic       s1_sign;
  exp_t       s1_exp;
  mant_t      s1_mant;
  logic       s1_is_nan, s1_is_snan, s1_is_inf, s1_is_zero;
  cast_op_e   s1_op;
  logic       s1_op_mod;
  roundmode_e s1_rnd_mode;

  // Aligned values feeding the rounding stage
  mant_t al_mant;
  exp_t  al_exp;
  rs_t   al_rs;
  logic  al_of, al_uf;

  // ----------------------------------------------------------
  // Handshake control
  // ----------------------------------------------------------
  cast_pipe_ctrl i_cast_pipe_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_ready_i ( out_ready_i ),
    .out_valid_o ( out_valid_o ),
    .s1_en_o     ( s1_en       ),
    .s2_en_o     ( s2_en       )
  );

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  cast_normalize i_cast_normalize (
    .clk_i      ( clk_i       ), .rst_n_i   ( rst_n_i    ), .s1_en_i    ( s1_en      ),
    .operand_i  ( operand_i   ), .op_i      ( op_i       ), .op_mod_i   ( op_mod_i   ),
    .rnd_mode_i ( rnd_mode_i  ), .sign_o    ( s1_sign    ), .exp_o      ( s1_exp     ),
    .mant_o     ( s1_mant     ), .is_nan_o  ( s1_is_nan  ), .is_snan_o  ( s1_is_snan ),
    .is_inf_o   ( s1_is_inf   ), .is_zero_o ( s1_is_zero ), .op_o       ( s1_op      ),
    .op_mod_o   ( s1_op_mod   ), .rnd_mode_o ( s1_rnd_mode )
  );

  cast_align i_cast_align (
    .exp_i       ( s1_exp    ), .mant_i      ( s1_mant ), .op_i ( s1_op ),
    .op_mod_i    ( s1_op_mod ), .mant_o      ( al_mant ), .final_exp_o ( al_exp ),
    .rs_o        ( al_rs     ), .of_before_o ( al_of   ), .uf_before_o ( al_uf  )
  );

  cast_round i_cast_round (
    .clk_i       ( clk_i      ), .rst_n_i     ( rst_n_i     ), .s2_en_i     ( s2_en     ),
    .sign_i      ( s1_sign    ), .mant_i      ( al_mant     ), .final_exp_i ( al_exp    ),
    .rs_i        ( al_rs      ), .of_before_i ( al_of       ), .uf_before_i ( al_uf     ),
    .is_nan_i    ( s1_is_nan  ), .is_snan_i   ( s1_is_snan  ), .is_inf_i    ( s1_is_inf ),
    .is_zero_i   ( s1_is_zero ), .op_i        ( s1_op       ), .op_mod_i    ( s1_op_mod ),
    .rnd_mode_i  ( s1_rnd_mode ), .result_o   ( result_o    ), .status_o    ( status_o  )
  );

endmodule

//--- verif/cast_unit_chk.sv
// Cast pipeline control checker with bound handshake assertions
`timescale 1ns/1ps

module cast_unit_chk import cast_pkg::*; (
  input logic clk_i,
  input logic rst_n_i,
  input logic out_ready_i,
  input logic out_valid_o,
  input logic s1_en_o,
  input logic s2_en_o
);

  logic s1_held;  // Stage-1 occupancy rebuilt from the enables

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_held <= 1'b0;
    end else if (s1_en_o || s2_en_o) begin
      s1_held <= s1_en_o;  // A load fills it and a lone move empties it
    end
  end

  // Output side stays empty under reset
  reset_empty_a: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_o)
    else $error("out_valid_o high while reset is held");

  // ----------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------
  hold_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o)
    else $error("Output item dropped without a transfer");

  s1_en_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s1_en_o && s1_held |-> s2_en_o)
    else $error("Stage-1 item overwritten before moving on");
  s2_en_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) s2_en_o |-> s1_held)
    else $error("Stage-2 enable with stage 1 empty");

endmodule

bind cast_pipe_ctrl cast_unit_chk i_cast_unit_chk (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .out_ready_i ( out_ready_i ),
  .out_valid_o ( out_valid_o ),
  .s1_en_o     ( s1_en_o     ),
  .s2_en_o     ( s2_en_o     )
);

//--- verif/cast_unit_tb.sv
// Testbench for the cast unit with file vectors, latency and back-pressure checks
`timescale 1ns/1ps

module cast_unit_tb import cast_pkg::*;;

  localparam int CYCLE_LIMIT = 1000;  // Per-phase cycle budget

  logic       clk, rst_n;
  logic       in_valid, in_ready, out_valid, out_ready, op_mod;
  word_t      operand, result;
  status_t    status;
  cast_op_e   op;
  roundmode_e rnd_mode;

  // Vector table with one entry per stimulus line
  logic [31:0] vec_op[$], vec_mod[$], vec_rnd[$], vec_opnd[$], vec_res[$], vec_flg[$];
  int pend_idx[$];    // Items in flight with the oldest first
  int pend_edge[$];   // Edge number of each acceptance
  int err_cnt, check_cnt;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  cast_unit i_cast_unit (
    .clk_i       ( clk       ), .rst_n_i     ( rst_n     ),
    .in_valid_i  ( in_valid  ), .in_ready_o  ( in_ready  ),
    .operand_i   ( operand   ), .op_i        ( op        ),
    .op_mod_i    ( op_mod    ), .rnd_mode_i  ( rnd_mode  ),
    .out_valid_o ( out_valid ), .out_ready_i ( out_ready ),
    .result_o    ( result    ), .status_o    ( status    )
  );

  // ----------------------------------------------------------
  // Vector file reader
  // ----------------------------------------------------------
  task automatic load_vectors();
    int fd, n;
    string line;
    logic [31:0] f_op, f_mod, f_rnd, f_opnd, f_res, f_flg;
    fd = $fopen("verif/cast_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Error: the stimulus file could not be opened");
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;  // Blank or column notes
      n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_mod, f_rnd, f_opnd, f_res, f_flg);
      if (n == 6) begin
        vec_op.push_back(f_op);
        vec_mod.push_back(f_mod);
        vec_rnd.push_back(f_rnd);
        vec_opnd.push_back(f_opnd);
        vec_res.push_back(f_res);
        vec_flg.push_back(f_flg);
      end
    end
    $fclose(fd);
  endtask

  // In-order compare of one transferred output
  task automatic check_output(input bit stall, input int edge_no);
    int idx, acc;
    if (pend_idx.size() == 0) begin
      $display("Error: an output came out with no item in flight");
      err_cnt++;
      return;
    end
    idx = pend_idx.pop_front();
    acc = pend_edge.pop_front();
    check_cnt++;
    if (result !== vec_res[idx]) begin
      $display("Fail at %0t: vector %0d result %h, expected %h", $time, idx, result,
               vec_res[idx]);
      err_cnt++;
    end
    if (status !== status_t'(vec_flg[idx])) begin
      $display("Fail at %0t: vector %0d status %b, expected %b", $time, idx, status,
               status_t'(vec_flg[idx]));
      err_cnt++;
    end
    if (!stall && (edge_no - acc) != 2) begin  // Latency only fixed without stalls
      $display("Fail at %0t: vector %0d took %0d cycles", $time, idx, edge_no - acc);
      err_cnt++;
    end
  endtask

  // ----------------------------------------------------------
  // One pass over all vectors with optional random stalls
  // ----------------------------------------------------------
  task automatic run_phase(input bit stall);
    int next, taken, edge_no;
    bit held;
    word_t held_res;
    status_t held_sts;
    next = 0;
    taken = 0;
    edge_no = 0;
    held = 1'b0;
    while (taken < vec_op.size() && edge_no < CYCLE_LIMIT) begin
      @(posedge clk);
      #1;
      edge_no++;
      in_valid = (next < vec_op.size());  // Held until accepted
      if (in_valid) begin
        op       = cast_op_e'(vec_op[next][0]);
        op_mod   = vec_mod[next][0];
        rnd_mode = roundmode_e'(vec_rnd[next][2:0]);
        operand  = vec_opnd[next];
      end
      out_ready = stall ? (($urandom % 100) >= 40) : 1'b1;
      @(negedge clk);  // Inputs settled before the transfer edge
      if (in_valid && in_ready) begin
        pend_idx.push_back(next);
        pend_edge.push_back(edge_no);
        next++;
      end
      if (out_valid && out_ready) begin
        check_output(stall, edge_no);
        taken++;
        held = 1'b0;
      end else if (out_valid) begin
        if (held && (result !== held_res || status !== held_sts)) begin
          $display("Fail at %0t: output changed while stalled", $time);
          err_cnt++;
        end
        held = 1'b1;
        held_res = result;
        held_sts = status;
      end
    end
    in_valid = 1'b0;
    if (taken < vec_op.size()) begin
      $display("Timeout: only %0d of %0d results came out", taken, vec_op.size());
      err_cnt++;
    end
  endtask

  initial begin
    void'($urandom(32'h2e6b7f73));
    err_cnt = 0;
    check_cnt = 0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    operand = '0;
    op = I2F;
    op_mod = 1'b0;
    rnd_mode = RNE;
    load_vectors();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_cnt++;
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin  // Idle state after reset
      $display("Fail at %0t: idle handshake out_valid %b in_ready %b", $time,
               out_valid, in_ready);
      err_cnt++;
    end
    if (vec_op.size() == 0) begin
      $display("Error: no vectors were read");
      err_cnt++;
    end else begin
      run_phase(1'b0);
      run_phase(1'b1);
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) $display("Simulation PASSED");
    else $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- cast_unit.f
logic/cast_pkg.sv
logic/cast_pipe_ctrl.sv
logic/cast_normalize.sv
logic/cast_align.sv
logic/cast_round.sv
logic/cast_unit.sv
verif/cast_unit_chk.sv
verif/cast_unit_tb.sv

//--- Makefile
# Verilator flow for the cast unit
TOOL     := verilator
TOP      := cast_unit_tb
FILELIST := cast_unit.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/cast_stimulus.txt
# op(0=I2F 1=F2I) mod(1=unsigned) rnd(0=RNE 1=RTZ 2=RDN 3=RUP 4=RMM) operand result
# last column is the expected status {NV,DZ,OF,UF,NX} in hex
0 0 0 00000001 3F800000 00
0 0 0 FFFFFF9C C2C80000 00
0 1 0 FFFFFFFF 4F800000 01
0 0 0 00000000 00000000 00
0 0 0 01000001 4B800000 01
0 0 3 01000001 4B800001 01
0 0 1 80000001 CEFFFFFF 01
1 0 0 40200000 00000002 01
1 0 4 40200000 00000003 01
1 0 2 BFC00000 FFFFFFFE 01
1 0 0 42C80000 00000064 00
1 0 0 4F000000 7FFFFFFF 10
1 0 0 CF800000 80000000 10
1 1 0 4F800000 FFFFFFFF 10
1 1 0 BF800000 00000000 10
1 1 0 BE800000 00000000 01
1 1 2 BE800000 00000000 10
1 0 0 FF800001 7FFFFFFF 10
1 0 0 FF800000 80000000 10
1 0 0 00000001 00000000 01
1 0 3 00000001 00000001 01
1 0 2 80000001 FFFFFFFF 01
